// File: verilog/rv64_pkg.sv
//####################################################################
// rv64_pkg
//   datapath and instruction widths
//   RV64I opcodes, funct3 and funct12 codes for the supported subset
//   data memory geometry and reset pc
//####################################################################

package rv64_pkg;

  // register / data width of the core
  localparam int XLEN     = 64;
  // every instruction is a full 32-bit word, no compressed set
  localparam int INST_W   = 32;
  // 32 architectural registers
  localparam int REG_ID_W = 5;
  // one mask bit per byte of a doubleword
  localparam int WMASK_W  = XLEN / 8;

  // major opcodes, bits [6:0] of the instruction
  // register-immediate arithmetic
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  // add upper immediate to pc
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  // jump and link, pc relative
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  // jump and link, register relative
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  // loads, width in funct3
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  // stores, width in funct3
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  // ecall / ebreak / csr space
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // funct3, bits [14:12]
  // addi inside OP_IMM
  localparam logic [2:0] F3_ADDI   = 3'b000;
  // doubleword width for ld / sd
  localparam logic [2:0] F3_DOUBLE = 3'b011;
  // privileged group inside OP_SYSTEM
  localparam logic [2:0] F3_PRIV   = 3'b000;

  // funct12, bits [31:20], tells ebreak apart from ecall
  localparam logic [11:0] F12_EBREAK = 12'h001;

  // private data memory, counted in doublewords
  localparam int DMEM_WORDS = 64;
  // word index width, address bits [DMEM_AW+2:3]
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // first fetch after reset
  localparam logic [XLEN-1:0] RESET_PC = 64'h0;

endpackage

// File: verilog/decoder.sv
//####################################################################
// decoder
//   combinational RV64 decode for addi, auipc, jal, jalr, sd, ld,
//   the all-zero nop and ebreak
//   register fields, sign-extended immediate, control strobes
//   flags every other encoding as not implemented
//####################################################################

`timescale 1ns/1ps

module decoder (
  input  logic [rv64_pkg::INST_W-1:0]   inst,

  output logic [rv64_pkg::REG_ID_W-1:0] rd,
  output logic [rv64_pkg::REG_ID_W-1:0] rs1,
  output logic [rv64_pkg::REG_ID_W-1:0] rs2,
  output logic [rv64_pkg::XLEN-1:0]     imm,
  output logic                          need_imm,
  output logic                          alu_add,
  output logic                          is_auipc,
  output logic                          is_jal,
  output logic                          is_jalr,
  output logic                          is_ebreak,
  output logic                          reg_wen,
  output logic                          mem_wen,
  output logic                          mem_ren,
  output logic [rv64_pkg::WMASK_W-1:0]  wmask,
  output logic                          inst_not_ipl
);

  import rv64_pkg::*;

  // raw instruction fields
  wire [6:0]  opcode  = inst[6:0];
  wire [2:0]  funct3  = inst[14:12];
  wire [11:0] funct12 = inst[31:20];

  // opcode hits
  wire op_imm    = (opcode == OP_IMM);
  wire op_auipc  = (opcode == OP_AUIPC);
  wire op_jal    = (opcode == OP_JAL);
  wire op_jalr   = (opcode == OP_JALR);
  wire op_load   = (opcode == OP_LOAD);
  wire op_store  = (opcode == OP_STORE);
  wire op_system = (opcode == OP_SYSTEM);

  // the eight supported encodings
  wire dec_addi   = op_imm & (funct3 == F3_ADDI);
  wire dec_auipc  = op_auipc;
  // jal / jalr carry no funct qualifier here
  wire dec_jal    = op_jal;
  wire dec_jalr   = op_jalr;
  wire dec_ld     = op_load & (funct3 == F3_DOUBLE);
  wire dec_sd     = op_store & (funct3 == F3_DOUBLE);
  wire dec_ebreak = op_system & (funct3 == F3_PRIV) & (funct12 == F12_EBREAK);
  // all-zero word, retires with no side effect
  wire dec_nop    = (inst == '0);

  // anything outside the list traps
  wire legal = dec_addi | dec_auipc | dec_jal | dec_jalr |
               dec_ld | dec_sd | dec_ebreak | dec_nop;

  // immediate format per instruction type
  wire i_type = dec_addi | dec_jalr | dec_ld;
  wire u_type = dec_auipc;
  wire j_type = dec_jal;
  wire s_type = dec_sd;

  // sign-extended immediates, one per format
  wire [XLEN-1:0] imm_i = {{(XLEN-12){inst[31]}}, inst[31:20]};
  wire [XLEN-1:0] imm_u = {{(XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  // J format scatters imm[20|10:1|11|19:12]
  wire [XLEN-1:0] imm_j = {{(XLEN-20){inst[31]}}, inst[19:12], inst[20],
                           inst[30:21], 1'b0};
  // S format splits imm across funct7 and rd
  wire [XLEN-1:0] imm_s = {{(XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};

  always_comb begin
    // no format selected for nop, ebreak or illegal words
    imm = '0;
    if (i_type) begin
      imm = imm_i;
    end else if (u_type) begin
      imm = imm_u;
    end else if (j_type) begin
      imm = imm_j;
    end else if (s_type) begin
      imm = imm_s;
    end
  end

  // register indices straight from the fixed positions
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // adder result is needed as a sum or an address
  assign alu_add  = legal & (dec_addi | dec_auipc | dec_jalr | dec_ld | dec_sd);
  // second operand comes from imm rather than rs2
  assign need_imm = legal & (dec_addi | dec_auipc | dec_jalr | dec_ld | dec_sd);

  // special-case strobes for the execute stage
  assign is_auipc  = legal & dec_auipc;
  assign is_jal    = legal & dec_jal;
  assign is_jalr   = legal & dec_jalr;
  assign is_ebreak = legal & dec_ebreak;

  // register write-back, ld included
  assign reg_wen = legal & (dec_addi | dec_auipc | dec_jal | dec_jalr | dec_ld);
  // memory side
  assign mem_wen = legal & dec_sd;
  assign mem_ren = legal & dec_ld;
  // only full doubleword stores exist, so all bytes or none
  assign wmask   = {WMASK_W{mem_wen}};

  // exception flag for the top level
  assign inst_not_ipl = ~legal;

endmodule

// File: verilog/regfile.sv
//####################################################################
// regfile
//   32 x XLEN integer registers, x0 hardwired to zero
//   two asynchronous read ports, one synchronous write port
//####################################################################

`timescale 1ns/1ps

module regfile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv64_pkg::REG_ID_W-1:0] raddr1,
  input  logic [rv64_pkg::REG_ID_W-1:0] raddr2,
  input  logic [rv64_pkg::REG_ID_W-1:0] waddr,
  input  logic [rv64_pkg::XLEN-1:0]     wdata,
  input  logic                          wen,
  output logic [rv64_pkg::XLEN-1:0]     rdata1,
  output logic [rv64_pkg::XLEN-1:0]     rdata2
);

  import rv64_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ID_W;

  logic [XLEN-1:0] regs [NUM_REGS];

  // whole file clears on reset, x0 never written
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // x0 forced to zero on read as well
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// File: verilog/alu_exec.sv
//####################################################################
// alu_exec
//   operand muxing for the shared adder
//   sum / address result, link value pc + 4
//   next pc for jal, jalr and sequential flow
//####################################################################

`timescale 1ns/1ps

module alu_exec (
  input  logic [rv64_pkg::XLEN-1:0] pc,
  input  logic [rv64_pkg::XLEN-1:0] rs1_val,
  input  logic [rv64_pkg::XLEN-1:0] rs2_val,
  input  logic [rv64_pkg::XLEN-1:0] imm,
  input  logic                      need_imm,
  input  logic                      alu_add,
  input  logic                      is_auipc,
  input  logic                      is_jal,
  input  logic                      is_jalr,
  output logic [rv64_pkg::XLEN-1:0] alu_result,
  output logic [rv64_pkg::XLEN-1:0] link,
  output logic [rv64_pkg::XLEN-1:0] next_pc
);

  import rv64_pkg::*;

  // fixed instruction size, no compressed forms
  localparam logic [XLEN-1:0] INST_BYTES = XLEN'(INST_W / 8);

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] seq_pc;
  logic            take_jump;

  // pc-relative forms add onto pc
  assign op_a = (is_auipc || is_jal) ? pc : rs1_val;

  // jal needs imm even though decode leaves need_imm low
  assign op_b = (need_imm || is_jal) ? imm : rs2_val;

  // one adder serves sums, load/store addresses and jump targets
  assign sum = op_a + op_b;

  // gated so non-arithmetic instructions show zero
  assign alu_result = alu_add ? sum : '0;

  // fall-through address, also the link value
  assign seq_pc = pc + INST_BYTES;
  assign link   = seq_pc;

  assign take_jump = is_jal | is_jalr;

  always_comb begin
    next_pc = seq_pc;
    if (take_jump) begin
      next_pc = sum;
      // jalr target loses its low bit
      if (is_jalr) begin
        next_pc[0] = 1'b0;
      end
    end
  end

endmodule

// File: verilog/lsu.sv
//####################################################################
// lsu
//   DMEM_WORDS x XLEN private data memory
//   byte-masked store at the clock edge
//   combinational doubleword load
//####################################################################

`timescale 1ns/1ps

module lsu (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [rv64_pkg::XLEN-1:0]    addr,
  input  logic [rv64_pkg::XLEN-1:0]    store_data,
  input  logic [rv64_pkg::WMASK_W-1:0] wmask,
  input  logic                         wen,
  output logic [rv64_pkg::XLEN-1:0]    load_data
);

  import rv64_pkg::*;

  logic [XLEN-1:0]    mem [DMEM_WORDS];
  logic [DMEM_AW-1:0] word_idx;

  // doubleword index, byte offset bits [2:0] dropped
  // upper address bits wrap onto the small array
  assign word_idx = addr[DMEM_AW+2:3];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // memory starts all zero after reset
      for (int w = 0; w < DMEM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (wen) begin
      // per-byte enables
      for (int b = 0; b < WMASK_W; b++) begin
        if (wmask[b]) begin
          mem[word_idx][b*8 +: 8] <= store_data[b*8 +: 8];
        end
      end
    end
  end

  // load returns the stored doubleword in the same cycle
  assign load_data = mem[word_idx];

endmodule

// File: verilog/rv64_core.sv
//####################################################################
// rv64_core
//   single-cycle RV64 subset core, top level
//   pc, halted and trap state
//   write-enable gating and write-back select
//   commit ports for an external reference model
//####################################################################

`timescale 1ns/1ps

module rv64_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [rv64_pkg::INST_W-1:0]   inst,
  output logic [rv64_pkg::XLEN-1:0]     pc,
  output logic                          halted,
  output logic                          trap,
  output logic                          commit_valid,
  output logic [rv64_pkg::XLEN-1:0]     commit_pc,
  output logic [rv64_pkg::REG_ID_W-1:0] commit_rd,
  output logic                          commit_wen,
  output logic [rv64_pkg::XLEN-1:0]     commit_wdata
);

  import rv64_pkg::*;

  // decode outputs
  logic [REG_ID_W-1:0] rd;
  logic [REG_ID_W-1:0] rs1;
  logic [REG_ID_W-1:0] rs2;
  logic [XLEN-1:0]     imm;
  logic                need_imm;
  logic                alu_add;
  logic                is_auipc;
  logic                is_jal;
  logic                is_jalr;
  logic                is_ebreak;
  logic                reg_wen;
  logic                mem_wen;
  logic                mem_ren;
  logic [WMASK_W-1:0]  wmask;
  logic                inst_not_ipl;

  // datapath values
  logic [XLEN-1:0] rs1_val;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] alu_result;
  logic [XLEN-1:0] link;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] wb_data;

  // retire qualifiers
  logic retire;
  logic reg_we;
  logic mem_we;

  decoder u_decoder (
    .inst         (inst),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm),
    .need_imm     (need_imm),
    .alu_add      (alu_add),
    .is_auipc     (is_auipc),
    .is_jal       (is_jal),
    .is_jalr      (is_jalr),
    .is_ebreak    (is_ebreak),
    .reg_wen      (reg_wen),
    .mem_wen      (mem_wen),
    .mem_ren      (mem_ren),
    .wmask        (wmask),
    .inst_not_ipl (inst_not_ipl)
  );

  regfile u_regfile (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .waddr  (rd),
    .wdata  (wb_data),
    .wen    (reg_we),
    .rdata1 (rs1_val),
    .rdata2 (rs2_val)
  );

  alu_exec u_alu_exec (
    .pc         (pc),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .imm        (imm),
    .need_imm   (need_imm),
    .alu_add    (alu_add),
    .is_auipc   (is_auipc),
    .is_jal     (is_jal),
    .is_jalr    (is_jalr),
    .alu_result (alu_result),
    .link       (link),
    .next_pc    (next_pc)
  );

  lsu u_lsu (
    .clk        (clk),
    .rst_n      (rst_n),
    .addr       (alu_result),
    .store_data (rs2_val),
    .wmask      (wmask),
    .wen        (mem_we),
    .load_data  (load_data)
  );

  // an instruction retires only while running and when legal
  assign retire = ~halted & ~inst_not_ipl;

  // no architectural side effect once halted or on a trap
  assign reg_we = retire & reg_wen;
  assign mem_we = retire & mem_wen;

  // write-back source, link wins for jumps
  always_comb begin
    if (is_jal || is_jalr) begin
      wb_data = link;
    end else if (mem_ren) begin
      wb_data = load_data;
    end else begin
      wb_data = alu_result;
    end
  end

  // pc holds on ebreak, trap and while halted
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (retire && !is_ebreak) begin
      pc <= next_pc;
    end
  end

  // halted is sticky until the next reset
  // trap marks a halt caused by an illegal word
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halted <= 1'b0;
      trap   <= 1'b0;
    end else if (!halted) begin
      if (is_ebreak || inst_not_ipl) begin
        halted <= 1'b1;
      end
      if (inst_not_ipl) begin
        trap <= 1'b1;
      end
    end
  end

  // commit report, valid in the cycle before the retiring edge
  // x0 writes still show commit_wen high
  assign commit_valid = retire;
  assign commit_pc    = pc;
  assign commit_rd    = rd;
  assign commit_wen   = reg_wen;
  assign commit_wdata = wb_data;

endmodule

// File: tests/tb_programs.svh
//######################################################################
// test program image for the rv64 core testbench
//   encoders for the I, S, U and J instruction formats
//   background fill of the instruction memory
//   fixed program ending in ebreak
//   random-immediate addi chain ending in an unimplemented word
//######################################################################

`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// program sizes and end state, worked out by hand
localparam int PROG1_LEN = 17;
localparam int PROG2_LEN = 8;
// two jumps each skip one word
localparam int PROG1_COMMITS = 15;
// the illegal word and the word after it never retire
localparam int PROG2_COMMITS = 6;
localparam logic [XLEN-1:0] PROG1_HALT_PC = 64'd64;
localparam logic [XLEN-1:0] PROG2_HALT_PC = 64'd24;

// fields in the order they sit in the word, msb first
function automatic logic [INST_W-1:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd,
                                               input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

// store offset split around the funct3 field
function automatic logic [INST_W-1:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [6:0] op);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], op};
endfunction

function automatic logic [INST_W-1:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                               input logic [6:0] op);
  return {imm, rd, op};
endfunction

// byte offset, bit 0 is implied zero
function automatic logic [INST_W-1:0] j_format(input logic [20:0] imm, input logic [4:0] rd,
                                               input logic [6:0] op);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op};
endfunction

// unused slots hold the word index over an all-ones opcode, so a runaway pc traps
task automatic fill_background();
  for (int i = 0; i < IMEM_WORDS; i++) begin
    imem[i] = {25'(i), 7'h7F};
  end
endtask

task automatic fixed_program();
  imem[0]  = i_format(12'd100, 5'd0, F3_ADDI, 5'd1, OP_IMM);
  imem[1]  = i_format(-12'sd300, 5'd1, F3_ADDI, 5'd2, OP_IMM);
  // write to x0, then read x0 back
  imem[2]  = i_format(12'd5, 5'd0, F3_ADDI, 5'd0, OP_IMM);
  imem[3]  = i_format(12'd7, 5'd0, F3_ADDI, 5'd3, OP_IMM);
  imem[4]  = u_format(20'h12345, 5'd4, OP_AUIPC);
  // jal over word 6
  imem[5]  = j_format(21'd8, 5'd5, OP_JAL);
  imem[6]  = i_format(12'd1, 5'd0, F3_ADDI, 5'd6, OP_IMM);
  // odd target 41, bit 0 cleared gives 40
  imem[7]  = i_format(12'd41, 5'd0, F3_ADDI, 5'd7, OP_IMM);
  imem[8]  = i_format(12'd0, 5'd7, F3_ADDI, 5'd8, OP_JALR);
  imem[9]  = i_format(12'd2, 5'd0, F3_ADDI, 5'd6, OP_IMM);
  imem[10] = i_format(12'd200, 5'd0, F3_ADDI, 5'd9, OP_IMM);
  imem[11] = s_format(12'd8, 5'd2, 5'd9, F3_DOUBLE, OP_STORE);
  imem[12] = i_format(12'd8, 5'd9, F3_DOUBLE, 5'd10, OP_LOAD);
  imem[13] = 32'h0000_0000;
  // negative store offset
  imem[14] = s_format(-12'sd8, 5'd4, 5'd9, F3_DOUBLE, OP_STORE);
  imem[15] = i_format(-12'sd8, 5'd9, F3_DOUBLE, 5'd11, OP_LOAD);
  imem[16] = i_format(F12_EBREAK, 5'd0, F3_PRIV, 5'd0, OP_SYSTEM);
endtask

task automatic random_program();
  int rnd;
  // x1..x6, each built from the one before
  for (int r = 0; r < 6; r++) begin
    rnd = $random(seed);
    imem[r] = i_format(rnd[11:0], 5'(r), F3_ADDI, 5'(r + 1), OP_IMM);
  end
  // slli is outside the supported set
  imem[6] = i_format(12'd1, 5'd1, 3'b001, 5'd1, OP_IMM);
  imem[7] = i_format(12'd1, 5'd0, F3_ADDI, 5'd1, OP_IMM);
endtask

`endif

// File: tests/tb_rv64_core.sv
//######################################################################
// testbench for the single-cycle rv64 core
//   clock, reset and combinational instruction memory
//   reference model with its own registers, data memory and pc
//   concurrent checks on the commit ports and the halt state
//   end-of-program checks and watchdog
//######################################################################

`timescale 1ns/1ps

module tb_rv64_core;

  import rv64_pkg::*;

  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 10;
  localparam int IMEM_WORDS   = 64;
  localparam int IMEM_AW      = 6;

  logic                clk = 1'b0;
  logic                rst_n;
  logic [INST_W-1:0]   inst;
  logic [XLEN-1:0]     pc;
  logic                halted;
  logic                trap;
  logic                commit_valid;
  logic [XLEN-1:0]     commit_pc;
  logic [REG_ID_W-1:0] commit_rd;
  logic                commit_wen;
  logic [XLEN-1:0]     commit_wdata;

  logic [INST_W-1:0] imem [IMEM_WORDS];
  int                seed = 21;
  int                commit_count;

  `include "tb_programs.svh"

  // 20 cycles per instruction of both programs, plus both resets
  localparam int WATCHDOG_NS =
    ((PROG1_LEN + PROG2_LEN) * 20 + 2 * RESET_CYCLES) * CLK_PERIOD;

  // reference model state
  logic [XLEN-1:0]     m_regs [32];
  logic [XLEN-1:0]     m_mem [DMEM_WORDS];
  logic [XLEN-1:0]     m_pc;
  logic                m_halted;
  logic                m_trap;
  // model view of the instruction at m_pc
  logic [INST_W-1:0]   m_inst;
  logic [XLEN-1:0]     rs1_v;
  logic [XLEN-1:0]     m_addr;
  logic                exp_legal;
  logic                exp_valid;
  logic                exp_ebreak;
  logic                exp_wen;
  logic                exp_store;
  logic [REG_ID_W-1:0] exp_rd;
  logic [XLEN-1:0]     exp_wdata;
  logic [XLEN-1:0]     exp_next;
  logic [DMEM_AW-1:0]  exp_widx;

  rv64_core u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .inst         (inst),
    .pc           (pc),
    .halted       (halted),
    .trap         (trap),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_wen   (commit_wen),
    .commit_wdata (commit_wdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // fetch answered in the same cycle
  assign inst = imem[pc[IMEM_AW+1:2]];

  // one ISA step from the model state
  always_comb begin
    m_inst     = imem[m_pc[IMEM_AW+1:2]];
    rs1_v      = m_regs[m_inst[19:15]];
    m_addr     = rs1_v + XLEN'($signed(m_inst[31:20]));
    exp_legal  = 1'b1;
    exp_ebreak = 1'b0;
    exp_wen    = 1'b0;
    exp_store  = 1'b0;
    exp_rd     = m_inst[11:7];
    exp_wdata  = '0;
    exp_next   = m_pc + 64'd4;
    case (m_inst[6:0])
      OP_IMM: begin
        exp_legal = (m_inst[14:12] == F3_ADDI);
        exp_wen   = 1'b1;
        exp_wdata = m_addr;
      end
      OP_AUIPC: begin
        exp_wen   = 1'b1;
        exp_wdata = m_pc + XLEN'($signed({m_inst[31:12], 12'h000}));
      end
      OP_JAL: begin
        exp_wen   = 1'b1;
        exp_wdata = m_pc + 64'd4;
        exp_next  = m_pc + XLEN'($signed({m_inst[31], m_inst[19:12], m_inst[20],
                                          m_inst[30:21], 1'b0}));
      end
      OP_JALR: begin
        exp_wen   = 1'b1;
        exp_wdata = m_pc + 64'd4;
        exp_next  = {m_addr[XLEN-1:1], 1'b0};
      end
      OP_LOAD: begin
        exp_legal = (m_inst[14:12] == F3_DOUBLE);
        exp_wen   = 1'b1;
        exp_wdata = m_mem[m_addr[DMEM_AW+2:3]];
      end
      OP_STORE: begin
        exp_legal = (m_inst[14:12] == F3_DOUBLE);
        exp_store = 1'b1;
        // store offset lives in funct7 and the rd field
        m_addr    = rs1_v + XLEN'($signed({m_inst[31:25], m_inst[11:7]}));
      end
      OP_SYSTEM: begin
        exp_ebreak = (m_inst[31:7] == {F12_EBREAK, 13'b0});
        exp_legal  = exp_ebreak;
      end
      default: begin
        // only the all-zero nop is legal here
        exp_legal = (m_inst == '0);
      end
    endcase
    exp_widx  = m_addr[DMEM_AW+2:3];
    exp_valid = ~m_halted & exp_legal;
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= '0;
      end
      for (int w = 0; w < DMEM_WORDS; w++) begin
        m_mem[w] <= '0;
      end
      m_pc     <= RESET_PC;
      m_halted <= 1'b0;
      m_trap   <= 1'b0;
    end else if (!m_halted) begin
      if (!exp_legal) begin
        m_halted <= 1'b1;
        m_trap   <= 1'b1;
      end else begin
        // ebreak retires but leaves the pc in place
        if (exp_ebreak) begin
          m_halted <= 1'b1;
        end else begin
          m_pc <= exp_next;
        end
        if (exp_wen && exp_rd != '0) begin
          m_regs[exp_rd] <= exp_wdata;
        end
        if (exp_store) begin
          m_mem[exp_widx] <= m_regs[m_inst[24:20]];
        end
      end
    end
  end

  always @(posedge clk) begin
    if (!rst_n) begin
      commit_count <= 0;
    end else if (commit_valid) begin
      commit_count <= commit_count + 1;
    end
  end

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  // commit ports against the model
  assert property (@(posedge clk) disable iff (!rst_n) commit_valid == exp_valid)
    else stop_on_error($sformatf("ERROR at %0t ns: commit_valid differs", $time));
  assert property (@(posedge clk) disable iff (!rst_n) commit_valid |-> commit_pc == m_pc)
    else stop_on_error($sformatf("ERROR at %0t ns: commit_pc differs", $time));
  assert property (@(posedge clk) disable iff (!rst_n) commit_valid |-> commit_wen == exp_wen)
    else stop_on_error($sformatf("ERROR at %0t ns: commit_wen differs", $time));
  assert property (@(posedge clk) disable iff (!rst_n)
                   (commit_valid && exp_wen) |-> commit_rd == exp_rd)
    else stop_on_error($sformatf("ERROR at %0t ns: commit_rd differs", $time));
  assert property (@(posedge clk) disable iff (!rst_n)
                   (commit_valid && exp_wen) |-> commit_wdata == exp_wdata)
    else stop_on_error($sformatf("ERROR at %0t ns: commit_wdata differs", $time));
  // pc and halt flags, also while halted
  assert property (@(posedge clk) disable iff (!rst_n) pc == m_pc)
    else stop_on_error($sformatf("ERROR at %0t ns: pc differs", $time));
  assert property (@(posedge clk) disable iff (!rst_n) halted == m_halted)
    else stop_on_error($sformatf("ERROR at %0t ns: halted differs", $time));
  assert property (@(posedge clk) disable iff (!rst_n) trap == m_trap)
    else stop_on_error($sformatf("ERROR at %0t ns: trap differs", $time));

  task automatic hold_reset();
    @(posedge clk);
    rst_n <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  // poll at the falling edge, then a few idle cycles for the checks
  task automatic wait_for_halt();
    @(negedge clk);
    while (!halted) @(negedge clk);
    repeat (5) @(negedge clk);
  endtask

  task automatic check_registers();
    for (int i = 0; i < 32; i++) begin
      assert (u_dut.u_regfile.regs[i] == m_regs[i])
        else stop_on_error($sformatf("ERROR at %0t ns: x%0d differs", $time, i));
    end
  endtask

  initial begin
    rst_n = 1'b0;
    fill_background();
    fixed_program();
    hold_reset();
    wait_for_halt();
    check_registers();
    assert (!trap && pc == PROG1_HALT_PC && commit_count == PROG1_COMMITS)
      else stop_on_error($sformatf("ERROR at %0t ns: wrong end state after ebreak", $time));

    // second program loaded while the core sits in reset
    fork
      hold_reset();
      begin
        @(negedge clk);
        @(negedge clk);
        fill_background();
        random_program();
      end
    join
    wait_for_halt();
    check_registers();
    if (trap && pc == PROG2_HALT_PC && commit_count == PROG2_COMMITS) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_error($sformatf("ERROR at %0t ns: wrong end state after trap", $time));
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("the core did not halt before the watchdog expired");
    $display("Testbench failed");
    $fatal(1);
  end

endmodule

// File: rv64_core.f
+incdir+tests
verilog/rv64_pkg.sv
verilog/decoder.sv
verilog/regfile.sv
verilog/alu_exec.sv
verilog/lsu.sv
verilog/rv64_core.sv
tests/tb_rv64_core.sv

// File: run.sh
#!/bin/sh
# build and run the rv64 core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 \
  --top-module tb_rv64_core \
  -f rv64_core.f

# $fatal gives a non-zero exit, so the log decides the result
./obj_dir/Vtb_rv64_core > sim.log 2>&1 || true
cat sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "run.sh: PASS"
  exit 0
else
  echo "run.sh: FAIL"
  exit 1
fi
